// File: common/mipsPkg.sv
package mipsPkg;

    // widths with a meaning of their own
    typedef logic [31:0] wordT;
    typedef logic [31:0] instrT;
    typedef logic [4:0]  regAddrT;
    typedef logic [15:0] immT;

    // 0 register file, 1 execute, 2 or 3 memory
    typedef logic [1:0] fwdSelT;

    typedef enum logic [3:0] {
        add,
        sub,
        andOp,
        orOp,
        xorOp,
        slt,
        sll,
        lui,
        pass
    } aluOpT;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opRegimm  = 6'h01;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // SPECIAL function field
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    // REGIMM forms, selected by the rt field
    localparam regAddrT rtBltz   = 5'd0;
    localparam regAddrT rtBgez   = 5'd1;
    localparam regAddrT rtBltzal = 5'd16;
    localparam regAddrT rtBgezal = 5'd17;

    // return address register for the linking forms
    localparam regAddrT linkReg = 5'd31;

endpackage

// File: source/pipeStage.sv
module pipeStage #(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             inValid,
    output logic             inReady,
    input  logic [width-1:0] inData,
    output logic             outValid,
    input  logic             outReady,
    output logic [width-1:0] outData
);

    // goes high one edge after reset, keeps ready low while in reset
    logic active;

    assign inReady = active & (~outValid | outReady);

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // payload only moves on an input transfer
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;
        end
    end

endmodule

// File: decode/controlUnit.sv
module controlUnit (
    input  logic [5:0]       opcode,
    input  logic [5:0]       funct,
    input  mipsPkg::regAddrT rtField,
    output mipsPkg::aluOpT   aluOp,
    output logic             regWriteC,
    output logic             memRead,
    output logic             memWrite,
    output logic             memToReg,
    output logic             aluSrcImm,
    output logic             immZeroExtend,
    output logic             destIsRt,
    output logic             isBranch,
    output logic             jump,
    output logic             jumpReg,
    output logic             reservedInstr
);

    always_comb begin
        aluOp         = mipsPkg::pass;
        regWriteC     = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memToReg      = 1'b0;
        aluSrcImm     = 1'b0;
        immZeroExtend = 1'b0;
        destIsRt      = 1'b0;
        isBranch      = 1'b0;
        jump          = 1'b0;
        jumpReg       = 1'b0;
        reservedInstr = 1'b0;

        case (opcode)
            mipsPkg::opSpecial: begin
                regWriteC = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: aluOp = mipsPkg::add;
                    mipsPkg::fnSubu: aluOp = mipsPkg::sub;
                    mipsPkg::fnAnd:  aluOp = mipsPkg::andOp;
                    mipsPkg::fnOr:   aluOp = mipsPkg::orOp;
                    mipsPkg::fnXor:  aluOp = mipsPkg::xorOp;
                    mipsPkg::fnSlt:  aluOp = mipsPkg::slt;
                    mipsPkg::fnSll:  aluOp = mipsPkg::sll;
                    mipsPkg::fnJr: begin
                        regWriteC = 1'b0;
                        jump      = 1'b1;
                        jumpReg   = 1'b1;
                    end
                    default: begin
                        regWriteC     = 1'b0;
                        reservedInstr = 1'b1;
                    end
                endcase
            end
            mipsPkg::opRegimm: begin
                // link write for the AL forms comes from branchJudge
                case (rtField)
                    mipsPkg::rtBltz, mipsPkg::rtBgez,
                    mipsPkg::rtBltzal, mipsPkg::rtBgezal: begin
                        isBranch = 1'b1;
                        destIsRt = 1'b1;
                    end
                    default: reservedInstr = 1'b1;
                endcase
            end
            mipsPkg::opJ: jump = 1'b1;
            mipsPkg::opJal: begin
                jump      = 1'b1;
                regWriteC = 1'b1;
            end
            mipsPkg::opBeq, mipsPkg::opBne: begin
                isBranch = 1'b1;
                aluOp    = mipsPkg::sub;
                destIsRt = 1'b1;
            end
            mipsPkg::opAddiu: begin
                aluOp     = mipsPkg::add;
                regWriteC = 1'b1;
                aluSrcImm = 1'b1;
                destIsRt  = 1'b1;
            end
            mipsPkg::opOri: begin
                aluOp         = mipsPkg::orOp;
                regWriteC     = 1'b1;
                aluSrcImm     = 1'b1;
                immZeroExtend = 1'b1;
                destIsRt      = 1'b1;
            end
            mipsPkg::opLui: begin
                aluOp     = mipsPkg::lui;
                regWriteC = 1'b1;
                aluSrcImm = 1'b1;
                destIsRt  = 1'b1;
            end
            mipsPkg::opLw: begin
                aluOp     = mipsPkg::add;
                regWriteC = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
                aluSrcImm = 1'b1;
                destIsRt  = 1'b1;
            end
            mipsPkg::opSw: begin
                aluOp     = mipsPkg::add;
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                destIsRt  = 1'b1;
            end
            default: reservedInstr = 1'b1;
        endcase
    end

endmodule

// File: decode/registerFile.sv
module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::regAddrT readAddrA,
    input  mipsPkg::regAddrT readAddrB,
    output mipsPkg::wordT    readDataA,
    output mipsPkg::wordT    readDataB,
    input  logic             writeEnable,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::wordT    writeData
);

    mipsPkg::wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // no bypass, same-cycle writes are forwarded from outside
    always_comb begin
        if (readAddrA == '0) begin
            readDataA = '0;
        end else begin
            readDataA = regs[readAddrA];
        end
    end

    always_comb begin
        if (readAddrB == '0) begin
            readDataB = '0;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

// File: decode/branchJudge.sv
module branchJudge (
    input  logic [5:0]       opcode,
    input  mipsPkg::regAddrT rtField,
    input  mipsPkg::wordT    rsValue,
    input  mipsPkg::wordT    rtValue,
    output logic             branchTaken,
    output logic             regWriteB
);

    logic rsNegative;

    assign rsNegative = rsValue[31];

    always_comb begin
        branchTaken = 1'b0;
        regWriteB   = 1'b0;
        case (opcode)
            mipsPkg::opBeq: branchTaken = (rsValue == rtValue);
            mipsPkg::opBne: branchTaken = (rsValue != rtValue);
            mipsPkg::opRegimm: begin
                case (rtField)
                    mipsPkg::rtBltz: branchTaken = rsNegative;
                    mipsPkg::rtBgez: branchTaken = ~rsNegative;
                    // link is written even when not taken
                    mipsPkg::rtBltzal: begin
                        branchTaken = rsNegative;
                        regWriteB   = 1'b1;
                    end
                    mipsPkg::rtBgezal: begin
                        branchTaken = ~rsNegative;
                        regWriteB   = 1'b1;
                    end
                    default: branchTaken = 1'b0;
                endcase
            end
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// File: decode/decodeStage.sv
module decodeStage (
    input  logic             clk,
    input  logic             reset,
    input  logic             inValid,
    output logic             inReady,
    input  mipsPkg::instrT   instr,
    input  mipsPkg::wordT    pc,
    output logic             outValid,
    input  logic             outReady,
    input  logic             wbEnable,
    input  mipsPkg::regAddrT wbAddr,
    input  mipsPkg::wordT    wbData,
    input  mipsPkg::fwdSelT  fwdSelA,
    input  mipsPkg::fwdSelT  fwdSelB,
    input  mipsPkg::wordT    aluOutE,
    input  mipsPkg::wordT    aluOutM,
    output mipsPkg::aluOpT   aluOp,
    output logic             regWrite,
    output logic             memRead,
    output logic             memWrite,
    output logic             memToReg,
    output logic             aluSrcImm,
    output mipsPkg::regAddrT destReg,
    output mipsPkg::wordT    rsValue,
    output mipsPkg::wordT    rtValue,
    output mipsPkg::wordT    immExt,
    output mipsPkg::wordT    pcPlus8,
    output logic             branchTaken,
    output logic             jump,
    output mipsPkg::wordT    target,
    output logic             inDelaySlot,
    output logic             reservedInstr,
    output mipsPkg::wordT    pcOut
);

    mipsPkg::regAddrT rs, rt, rd;
    mipsPkg::immT     imm;
    mipsPkg::wordT    regA, regB, pcPlus4, branchTarget, jumpTarget;
    logic regWriteC, regWriteB, immZeroExtend, destIsRt, isBranch, jumpReg;
    logic advance;

    function automatic mipsPkg::wordT fwdMux(
        input mipsPkg::fwdSelT sel,
        input mipsPkg::wordT   regVal,
        input mipsPkg::wordT   exVal,
        input mipsPkg::wordT   memVal
    );
        case (sel)
            2'd0:    return regVal;
            2'd1:    return exVal;
            default: return memVal;
        endcase
    endfunction

    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = instr[15:0];

    // handshake passes straight through
    assign outValid = inValid;
    assign inReady  = outReady;
    assign advance  = inValid & outReady;

    assign rsValue = fwdMux(fwdSelA, regA, aluOutE, aluOutM);
    assign rtValue = fwdMux(fwdSelB, regB, aluOutE, aluOutM);

    assign regWrite = regWriteC | regWriteB;
    assign immExt   = immZeroExtend ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    always_comb begin
        if (regWriteB || instr[31:26] == mipsPkg::opJal) begin
            destReg = mipsPkg::linkReg;
        end else if (destIsRt) begin
            destReg = rt;
        end else begin
            destReg = rd;
        end
    end

    assign pcPlus4      = pc + 32'd4;
    assign pcPlus8      = pc + 32'd8;
    assign pcOut        = pc;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
    assign target       = jumpReg ? rsValue : (jump ? jumpTarget : branchTarget);

    // next instruction sits in the delay slot
    always_ff @(posedge clk) begin
        if (reset) begin
            inDelaySlot <= 1'b0;
        end else if (advance) begin
            inDelaySlot <= isBranch | jump;
        end
    end

    controlUnit u_controlUnit (
        .opcode        (instr[31:26]),
        .funct         (instr[5:0]),
        .rtField       (rt),
        .aluOp         (aluOp),
        .regWriteC     (regWriteC),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .memToReg      (memToReg),
        .aluSrcImm     (aluSrcImm),
        .immZeroExtend (immZeroExtend),
        .destIsRt      (destIsRt),
        .isBranch      (isBranch),
        .jump          (jump),
        .jumpReg       (jumpReg),
        .reservedInstr (reservedInstr)
    );

    registerFile u_registerFile (
        .clk         (clk),
        .reset       (reset),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .readDataA   (regA),
        .readDataB   (regB),
        .writeEnable (wbEnable),
        .writeAddr   (wbAddr),
        .writeData   (wbData)
    );

    branchJudge u_branchJudge (
        .opcode      (instr[31:26]),
        .rtField     (rt),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .branchTaken (branchTaken),
        .regWriteB   (regWriteB)
    );

endmodule

// File: source/decodeTop.sv
module decodeTop (
    input  logic             clk,
    input  logic             reset,
    input  logic             inValid,
    output logic             inReady,
    input  mipsPkg::instrT   inInstr,
    input  mipsPkg::wordT    inPc,
    input  logic             wbEnable,
    input  mipsPkg::regAddrT wbAddr,
    input  mipsPkg::wordT    wbData,
    input  mipsPkg::fwdSelT  fwdSelA,
    input  mipsPkg::fwdSelT  fwdSelB,
    input  mipsPkg::wordT    aluOutE,
    input  mipsPkg::wordT    aluOutM,
    output logic             outValid,
    input  logic             outReady,
    output mipsPkg::aluOpT   aluOp,
    output logic             regWrite,
    output logic             memRead,
    output logic             memWrite,
    output logic             memToReg,
    output logic             aluSrcImm,
    output mipsPkg::regAddrT destReg,
    output mipsPkg::wordT    rsValue,
    output mipsPkg::wordT    rtValue,
    output mipsPkg::wordT    immExt,
    output mipsPkg::wordT    pcPlus8,
    output logic             branchTaken,
    output logic             jump,
    output mipsPkg::wordT    target,
    output logic             inDelaySlot,
    output logic             reservedInstr,
    output mipsPkg::wordT    pcOut
);

    // instr + pc, and the full decoded bundle
    localparam int inWidth  = 64;
    localparam int outWidth = 210;

    logic [inWidth-1:0]  inPayload, idPayload;
    logic [outWidth-1:0] decPayload, outPayload;
    logic                idValid, idReady, decValid, decReady;

    mipsPkg::aluOpT   decAluOp;
    mipsPkg::regAddrT decDestReg;
    mipsPkg::wordT    decRsValue, decRtValue, decImmExt, decPcPlus8, decTarget, decPcOut;
    logic decRegWrite, decMemRead, decMemWrite, decMemToReg, decAluSrcImm;
    logic decBranchTaken, decJump, decInDelaySlot, decReservedInstr;
    logic [3:0] aluOpBits;

    assign inPayload = {inInstr, inPc};

    assign decPayload = {decAluOp, decRegWrite, decMemRead, decMemWrite, decMemToReg,
                         decAluSrcImm, decDestReg, decRsValue, decRtValue, decImmExt,
                         decPcPlus8, decBranchTaken, decJump, decTarget, decInDelaySlot,
                         decReservedInstr, decPcOut};

    assign {aluOpBits, regWrite, memRead, memWrite, memToReg, aluSrcImm, destReg,
            rsValue, rtValue, immExt, pcPlus8, branchTaken, jump, target, inDelaySlot,
            reservedInstr, pcOut} = outPayload;
    assign aluOp = mipsPkg::aluOpT'(aluOpBits);

    pipeStage #(.width(inWidth)) inStage (
        .clk, .reset, .inValid, .inReady,
        .inData   (inPayload),
        .outValid (idValid),
        .outReady (idReady),
        .outData  (idPayload)
    );

    decodeStage u_decodeStage (
        .clk, .reset, .wbEnable, .wbAddr, .wbData,
        .fwdSelA, .fwdSelB, .aluOutE, .aluOutM,
        .inValid (idValid),  .inReady (idReady),
        .instr   (idPayload[63:32]), .pc (idPayload[31:0]),
        .outValid (decValid), .outReady (decReady),
        .aluOp (decAluOp), .regWrite (decRegWrite), .memRead (decMemRead),
        .memWrite (decMemWrite), .memToReg (decMemToReg), .aluSrcImm (decAluSrcImm),
        .destReg (decDestReg), .rsValue (decRsValue), .rtValue (decRtValue),
        .immExt (decImmExt), .pcPlus8 (decPcPlus8), .branchTaken (decBranchTaken),
        .jump (decJump), .target (decTarget), .inDelaySlot (decInDelaySlot),
        .reservedInstr (decReservedInstr), .pcOut (decPcOut)
    );

    pipeStage #(.width(outWidth)) outStage (
        .clk, .reset, .outValid, .outReady,
        .inValid (decValid),
        .inReady (decReady),
        .inData  (decPayload),
        .outData (outPayload)
    );

endmodule

// File: dv/decodeTop_checker.sv
module decodeTop_checker (
    input logic        clk,
    input logic        reset,
    input logic        inValid,
    input logic        inReady,
    input logic [31:0] inInstr,
    input logic [31:0] inPc,
    input logic        outValid,
    input logic        outReady,
    input logic [4:0]  destReg,
    input logic [31:0] rsValue,
    input logic [31:0] rtValue,
    input logic [31:0] target,
    input logic [31:0] pcOut,
    input logic        regWrite,
    input logic        reservedInstr
);

    int failCount = 0;

    // fetch side keeps its request until taken
    inputHeld: assert property (@(posedge clk) disable iff (reset)
        inValid && !inReady |=> inValid && $stable(inInstr) && $stable(inPc))
        else begin
            failCount++;
            $error("inValid dropped or payload changed before acceptance");
        end

    outputStable: assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable({destReg, rsValue, rtValue, target,
                                                        pcOut, regWrite, reservedInstr}))
        else begin
            failCount++;
            $error("output bundle changed while stalled");
        end

    quietInReset: assert property (@(posedge clk) reset |=> !outValid)
        else begin
            failCount++;
            $error("outValid high during reset");
        end

endmodule

bind decodeTop decodeTop_checker u_checker (.*);

// File: dv/decodeTb.sv
module decodeTb;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [1:0]  selA;
        logic [1:0]  selB;
        logic [3:0]  aluOp;
        logic [8:0]  flags;
        logic [4:0]  dest;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
        logic [31:0] target;
        logic        chkTarget;
    } entryT;

    localparam logic [31:0] valE = 32'he0e0_0001;
    localparam logic [31:0] valM = 32'ha0a0_0002;
    localparam int burstLen = 13;

    logic             clk = 1'b0;
    logic             reset;
    logic             inValid;
    logic             inReady;
    mipsPkg::instrT   inInstr;
    mipsPkg::wordT    inPc;
    logic             wbEnable;
    mipsPkg::regAddrT wbAddr;
    mipsPkg::wordT    wbData;
    mipsPkg::fwdSelT  fwdSelA;
    mipsPkg::fwdSelT  fwdSelB;
    mipsPkg::wordT    aluOutE;
    mipsPkg::wordT    aluOutM;
    logic             outValid;
    logic             outReady;
    mipsPkg::aluOpT   aluOp;
    logic             regWrite;
    logic             memRead;
    logic             memWrite;
    logic             memToReg;
    logic             aluSrcImm;
    mipsPkg::regAddrT destReg;
    mipsPkg::wordT    rsValue;
    mipsPkg::wordT    rtValue;
    mipsPkg::wordT    immExt;
    mipsPkg::wordT    pcPlus8;
    logic             branchTaken;
    logic             jump;
    mipsPkg::wordT    target;
    logic             inDelaySlot;
    logic             reservedInstr;
    mipsPkg::wordT    pcOut;

    entryT entries[$];
    int    curEntry;

    always #50 clk = ~clk;

    decodeTop u_decodeTop (.*);

    // a bound assertion failure ends the run at once
    always @(negedge clk) begin
        if (u_decodeTop.u_checker.failCount != 0) begin
            abortRun("a handshake assertion in the bound checker failed");
        end
    end

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sh,
                                         input logic [5:0] fn);
        return {mipsPkg::opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void addEntry(input logic [31:0] instr, input logic [31:0] pc,
                                     input logic [1:0] selA, input logic [1:0] selB,
                                     input logic [3:0] op, input logic [8:0] flags,
                                     input logic [4:0] dest, input logic [31:0] rsVal,
                                     input logic [31:0] rtVal, input logic [31:0] imm,
                                     input logic [31:0] tgt, input logic chkTarget);
        entries.push_back('{instr, pc, selA, selB, op, flags, dest, rsVal, rtVal, imm,
                            tgt, chkTarget});
    endfunction

    // flag bits msb first regWrite memRead memWrite memToReg aluSrcImm taken jump
    // delaySlot reserved
    function automatic void buildTable();
        addEntry(encR(1, 2, 9, 0, mipsPkg::fnAddu), 32'h0040_0000, 0, 0, mipsPkg::add,
                 9'b100000000, 9, 32'h5, 32'h3, 32'h0000_4821, 0, 0);
        addEntry(encR(4, 1, 10, 0, mipsPkg::fnSubu), 32'h0040_0004, 0, 0, mipsPkg::sub,
                 9'b100000000, 10, 32'h1234_5678, 32'h5, 32'h0000_5023, 0, 0);
        addEntry(encR(3, 5, 11, 0, mipsPkg::fnAnd), 32'h0040_0008, 0, 0, mipsPkg::andOp,
                 9'b100000000, 11, 32'hffff_fff0, 32'h0000_ff00, 32'h0000_5824, 0, 0);
        addEntry(encR(1, 8, 12, 0, mipsPkg::fnOr), 32'h0040_000c, 0, 0, mipsPkg::orOp,
                 9'b100000000, 12, 32'h5, 32'hc, 32'h0000_6025, 0, 0);
        addEntry(encR(4, 5, 13, 0, mipsPkg::fnXor), 32'h0040_0010, 0, 0, mipsPkg::xorOp,
                 9'b100000000, 13, 32'h1234_5678, 32'h0000_ff00, 32'h0000_6826, 0, 0);
        addEntry(encR(3, 2, 14, 0, mipsPkg::fnSlt), 32'h0040_0014, 0, 0, mipsPkg::slt,
                 9'b100000000, 14, 32'hffff_fff0, 32'h3, 32'h0000_702a, 0, 0);
        addEntry(encR(0, 7, 15, 4, mipsPkg::fnSll), 32'h0040_0018, 0, 0, mipsPkg::sll,
                 9'b100000000, 15, 32'h0, 32'h8000_0000, 32'h0000_7900, 0, 0);
        addEntry(encI(mipsPkg::opAddiu, 1, 16, 16'hfff8), 32'h0040_001c, 0, 0, mipsPkg::add,
                 9'b100010000, 16, 32'h5, 32'h0, 32'hffff_fff8, 0, 0);
        addEntry(encI(mipsPkg::opOri, 5, 17, 16'h8001), 32'h0040_0020, 0, 0, mipsPkg::orOp,
                 9'b100010000, 17, 32'h0000_ff00, 32'h0, 32'h0000_8001, 0, 0);
        addEntry(encI(mipsPkg::opLui, 0, 18, 16'h1234), 32'h0040_0024, 0, 0, mipsPkg::lui,
                 9'b100010000, 18, 32'h0, 32'h0, 32'h0000_1234, 0, 0);
        addEntry(encI(mipsPkg::opLw, 8, 19, 16'hfffc), 32'h0040_0028, 0, 0, mipsPkg::add,
                 9'b110110000, 19, 32'hc, 32'h0, 32'hffff_fffc, 0, 0);
        addEntry(encI(mipsPkg::opSw, 4, 2, 16'h0008), 32'h0040_002c, 0, 0, mipsPkg::add,
                 9'b001010000, 2, 32'h1234_5678, 32'h3, 32'h8, 0, 0);
        // $0 was written with a nonzero value during preload
        addEntry(encR(0, 1, 20, 0, mipsPkg::fnAddu), 32'h0040_0030, 0, 0, mipsPkg::add,
                 9'b100000000, 20, 32'h0, 32'h5, 32'hffff_a021, 0, 0);
        // forwarding from execute and memory
        addEntry(encR(1, 2, 21, 0, mipsPkg::fnAddu), 32'h0040_0034, 1, 2, mipsPkg::add,
                 9'b100000000, 21, valE, valM, 32'hffff_a821, 0, 0);
        addEntry(encR(4, 3, 22, 0, mipsPkg::fnSubu), 32'h0040_0038, 2, 1, mipsPkg::sub,
                 9'b100000000, 22, valM, valE, 32'hffff_b023, 0, 0);
        addEntry(encR(5, 6, 23, 0, mipsPkg::fnOr), 32'h0040_003c, 3, 0, mipsPkg::orOp,
                 9'b100000000, 23, valM, 32'h5, 32'hffff_b825, 0, 0);
        // branches taken and not taken
        addEntry(encI(mipsPkg::opBeq, 1, 6, 16'h0004), 32'h0040_0040, 0, 0, mipsPkg::sub,
                 9'b000001000, 6, 32'h5, 32'h5, 32'h4, 32'h0040_0054, 1);
        addEntry(encI(mipsPkg::opBne, 1, 6, 16'hfffe), 32'h0040_0044, 0, 0, mipsPkg::sub,
                 9'b000000010, 6, 32'h5, 32'h5, 32'hffff_fffe, 32'h0040_0040, 1);
        addEntry(encI(mipsPkg::opRegimm, 3, mipsPkg::rtBltz, 16'h0010), 32'h0040_0048, 0, 0,
                 mipsPkg::pass, 9'b000001010, 0, 32'hffff_fff0, 32'h0, 32'h10,
                 32'h0040_008c, 1);
        addEntry(encI(mipsPkg::opRegimm, 3, mipsPkg::rtBgez, 16'h0010), 32'h0040_004c, 0, 0,
                 mipsPkg::pass, 9'b000000010, 1, 32'hffff_fff0, 32'h5, 32'h10,
                 32'h0040_0090, 1);
        addEntry(encI(mipsPkg::opRegimm, 7, mipsPkg::rtBltzal, 16'h0020), 32'h0040_0050, 0, 0,
                 mipsPkg::pass, 9'b100001010, 31, 32'h8000_0000, 32'h0, 32'h20,
                 32'h0040_00d4, 1);
        addEntry(encI(mipsPkg::opRegimm, 7, mipsPkg::rtBgezal, 16'h0020), 32'h0040_0054, 0, 0,
                 mipsPkg::pass, 9'b100000010, 31, 32'h8000_0000, 32'h0, 32'h20,
                 32'h0040_00d8, 1);
        // jumps take the upper pc nibble from pc+4
        addEntry({mipsPkg::opJ, 26'h000_0400}, 32'hbfc0_0100, 0, 0, mipsPkg::pass,
                 9'b000000110, 0, 32'h0, 32'h0, 32'h400, 32'hb000_1000, 1);
        addEntry({mipsPkg::opJal, 26'h000_0800}, 32'hbfc0_0104, 0, 0, mipsPkg::pass,
                 9'b100000110, 31, 32'h0, 32'h0, 32'h800, 32'hb000_2000, 1);
        addEntry(encR(4, 0, 0, 0, mipsPkg::fnJr), 32'h0040_0060, 0, 0, mipsPkg::pass,
                 9'b000000110, 0, 32'h1234_5678, 32'h0, 32'h8, 32'h1234_5678, 1);
        addEntry(encR(2, 2, 9, 0, mipsPkg::fnAddu), 32'h0040_0064, 0, 0, mipsPkg::add,
                 9'b100000010, 9, 32'h3, 32'h3, 32'h0000_4821, 0, 0);
        // unsupported encodings
        // the last one leaves the delay-slot flag clear for the burst
        addEntry(32'hfc00_0000, 32'h0040_0068, 0, 0, mipsPkg::pass,
                 9'b000000001, 0, 32'h0, 32'h0, 32'h0, 0, 0);
        addEntry(encR(1, 2, 9, 0, 6'h3f), 32'h0040_006c, 0, 0, mipsPkg::pass,
                 9'b000000001, 9, 32'h5, 32'h3, 32'h0000_483f, 0, 0);
        addEntry(encI(mipsPkg::opRegimm, 1, 2, 16'h0004), 32'h0040_0070, 0, 0, mipsPkg::pass,
                 9'b000000001, 0, 32'h5, 32'h3, 32'h4, 0, 0);
    endfunction

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEq(input string field, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: entry %0d %s is %h, expected %h",
                     $time, curEntry, field, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic checkOutputs(input entryT e);
        checkEq("aluOp", 32'(aluOp), 32'(e.aluOp));
        checkEq("control flags", 32'({regWrite, memRead, memWrite, memToReg, aluSrcImm,
                branchTaken, jump, inDelaySlot, reservedInstr}), 32'(e.flags));
        checkEq("destReg", 32'(destReg), 32'(e.dest));
        checkEq("rsValue", rsValue, e.rsVal);
        checkEq("rtValue", rtValue, e.rtVal);
        checkEq("immExt", immExt, e.imm);
        checkEq("pcPlus8", pcPlus8, e.pc + 32'd8);
        checkEq("pcOut", pcOut, e.pc);
        if (e.chkTarget) begin
            checkEq("target", target, e.target);
        end
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        wbEnable = 1'b1;
        wbAddr   = addr;
        wbData   = data;
        @(posedge clk);
        #10;
        wbEnable = 1'b0;
    endtask

    // returns right after the edge that takes the instruction
    task automatic sendInstr(input entryT e);
        int cycles = 0;
        inValid = 1'b1;
        inInstr = e.instr;
        inPc    = e.pc;
        @(negedge clk);
        while (!inReady) begin
            cycles++;
            if (cycles > 20) begin
                abortRun("timeout: the input handshake never completed");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        inValid = 1'b0;
    endtask

    task automatic waitOutput();
        int cycles = 0;
        @(negedge clk);
        while (!outValid) begin
            cycles++;
            if (cycles > 20) begin
                abortRun("timeout: outValid never came up");
            end
            @(negedge clk);
        end
    endtask

    task automatic drainBurst();
        int got = 0;
        int cycles = 0;
        while (got < burstLen) begin
            @(posedge clk);
            #10;
            outReady = ($urandom % 3) != 0;
            @(negedge clk);
            if (outValid && outReady) begin
                curEntry = got;
                checkOutputs(entries[got]);
                got++;
            end
            cycles++;
            if (cycles > 300) begin
                abortRun("timeout: the output handshake hung during the burst");
            end
        end
        @(posedge clk);
        #10;
        outReady = 1'b1;
    endtask

    initial begin
        void'($urandom(32'h4e2));
        reset    = 1'b1;
        inValid  = 1'b0;
        inInstr  = '0;
        inPc     = '0;
        wbEnable = 1'b0;
        wbAddr   = '0;
        wbData   = '0;
        fwdSelA  = '0;
        fwdSelB  = '0;
        aluOutE  = valE;
        aluOutM  = valM;
        outReady = 1'b1;
        curEntry = 0;
        buildTable();
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        writeReg(0, 32'hdead_beef);
        writeReg(1, 32'h0000_0005);
        writeReg(2, 32'h0000_0003);
        writeReg(3, 32'hffff_fff0);
        writeReg(4, 32'h1234_5678);
        writeReg(5, 32'h0000_ff00);
        writeReg(6, 32'h0000_0005);
        writeReg(7, 32'h8000_0000);
        writeReg(8, 32'h0000_000c);

        // one instruction at a time with its selects held until it leaves decode
        for (int i = 0; i < entries.size(); i++) begin
            curEntry = i;
            fwdSelA  = entries[i].selA;
            fwdSelB  = entries[i].selB;
            sendInstr(entries[i]);
            waitOutput();
            checkOutputs(entries[i]);
            @(posedge clk);
            #10;
        end

        // burst of the ALU entries under random output stalls
        fwdSelA = '0;
        fwdSelB = '0;
        fork
            begin
                for (int i = 0; i < burstLen; i++) begin
                    sendInstr(entries[i]);
                end
            end
            drainBurst();
        join

        if (u_decodeTop.u_checker.failCount == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("handshake assertions failed %0d times", u_decodeTop.u_checker.failCount);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: flist.f
common/mipsPkg.sv
source/pipeStage.sv
decode/controlUnit.sv
decode/registerFile.sv
decode/branchJudge.sv
decode/decodeStage.sv
source/decodeTop.sv
dv/decodeTop_checker.sv
dv/decodeTb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run decodeTb and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module decodeTb -f flist.f -Mdir obj_dir -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
